// File: design/lsu_ctrl.sv
`default_nettype none

module lsu_ctrl #(
  parameter int unsigned ADDR_W = 32
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              data_req_ex_i,
  input  wire lsu_pkg::data_type_e data_type_i,
  input  wire logic [ADDR_W-1:0] addr_i,
  input  wire logic              we_i,
  input  wire logic              data_gnt_i,
  input  wire logic              data_rvalid_i,
  input  wire logic              data_err_i,
  output logic                   data_req_o,
  output logic                   addr_incr_req_o,
  output logic                   data_valid_o,
  output logic                   second_part_o,
  output logic      [ADDR_W-1:0] addr_last_o,
  output logic                   load_err_o,
  output logic                   store_err_o,
  output logic                   busy_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID
  } ls_state_e;

  ls_state_e ls_cs, ls_ns;

  // access crosses an 8-byte boundary
  logic split_access;
  // set on the first grant of a split access and cleared at its end
  logic split_q, split_d;
  // write flag of the outstanding access
  logic we_q;
  logic [ADDR_W-1:0] addr_last_q;

  // word at offset 5..7 or half word at offset 7
  assign split_access =
      ((data_type_i == lsu_pkg::DT_WORD) && (addr_i[2:0] > 3'd4)) ||
      ((data_type_i == lsu_pkg::DT_HALF) && (addr_i[2:0] == 3'd7));

  //////////////////////////////////////////////////
  // access FSM
  //////////////////////////////////////////////////

  always_comb begin
    ls_ns           = ls_cs;
    split_d         = split_q;
    data_req_o      = 1'b0;
    data_valid_o    = 1'b0;
    addr_incr_req_o = 1'b0;
    second_part_o   = 1'b0;
    unique case (ls_cs)
      IDLE: begin
        if (data_req_ex_i) begin
          data_req_o = 1'b1;
          if (data_gnt_i) begin
            split_d = split_access;
            ls_ns   = split_access ? WAIT_RVALID_MIS : WAIT_RVALID;
          end else begin
            ls_ns   = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end
      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          split_d = 1'b1;
          ls_ns   = WAIT_RVALID_MIS;
        end
      end
      WAIT_RVALID_MIS: begin
        // execute stage moves on to address + 8
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          if (data_err_i) begin
            // first part failed so no second request goes out
            data_valid_o = 1'b1;
            split_d      = 1'b0;
            ls_ns        = IDLE;
          end else begin
            data_req_o    = 1'b1;
            second_part_o = 1'b1;
            ls_ns         = data_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end
        end
      end
      WAIT_GNT: begin
        addr_incr_req_o = split_q;
        second_part_o   = split_q;
        data_req_o      = 1'b1;
        if (data_gnt_i) begin
          ls_ns = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        second_part_o = split_q;
        if (data_rvalid_i) begin
          data_valid_o = 1'b1;
          split_d      = 1'b0;
          ls_ns        = IDLE;
        end
      end
      default: begin
        ls_ns = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_cs       <= IDLE;
      split_q     <= 1'b0;
      we_q        <= 1'b0;
      addr_last_q <= '0;
    end else begin
      ls_cs   <= ls_ns;
      split_q <= split_d;
      if (data_req_o && data_gnt_i) begin
        we_q        <= we_i;
        // keep the failing address for trap reporting and the address generator
        addr_last_q <= addr_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // status outputs
  //////////////////////////////////////////////////

  assign addr_last_o = addr_last_q;

  // error type follows the access that owns the rvalid
  assign load_err_o  = data_rvalid_i & data_err_i & ~we_q;
  assign store_err_o = data_rvalid_i & data_err_i &  we_q;

  assign busy_o = (ls_cs == WAIT_RVALID) | (ls_cs == WAIT_RVALID_MIS) | data_req_o;

endmodule

`default_nettype wire

// File: design/lsu_load_align.sv
`default_nettype none

module lsu_load_align (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         data_gnt_i,
  input  wire logic                         data_rvalid_i,
  input  wire logic                         second_part_i,
  input  wire logic [lsu_pkg::offs_w_c-1:0] addr_offs_i,
  input  wire lsu_pkg::data_type_e          data_type_i,
  input  wire logic                         sign_ext_i,
  input  wire logic                         we_i,
  input  wire logic [lsu_pkg::bus_w_c-1:0]  data_rdata_i,
  output logic      [lsu_pkg::bus_w_c-1:0]  rdata_o
);

  // controls of the outstanding access, captured on grant
  logic [lsu_pkg::offs_w_c-1:0] offs_q;
  lsu_pkg::data_type_e          data_type_q;
  logic                         sign_ext_q;
  logic                         we_q;
  // outstanding access is the second half of a split load
  logic                         part2_q;

  // first-part data of a split load
  logic [lsu_pkg::bus_w_c-1:0]   rdata_q;
  logic [lsu_pkg::bus_w_c-1:0]   rdata_lo;
  logic [2*lsu_pkg::bus_w_c-1:0] rdata_dbl;
  logic [lsu_pkg::bus_w_c-1:0]   rdata_al;

  //////////////////////////////////////////////////
  // control capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offs_q      <= '0;
      data_type_q <= lsu_pkg::DT_WORD;
      sign_ext_q  <= 1'b0;
      we_q        <= 1'b0;
      part2_q     <= 1'b0;
    end else if (data_gnt_i) begin
      offs_q      <= addr_offs_i;
      data_type_q <= data_type_i;
      sign_ext_q  <= sign_ext_i;
      we_q        <= we_i;
      // second_part_i is already high when the second request is granted
      part2_q     <= second_part_i;
    end
  end

  // keep the response of every read that is not a second part
  // a split load reads it back on its second rvalid
  always_ff @(posedge clk_i) begin
    if (data_rvalid_i && !we_q && !part2_q) begin
      rdata_q <= data_rdata_i;
    end
  end

  //////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////

  // lower result bytes come from the top lanes of the first word on a split load
  assign rdata_lo = part2_q ? rdata_q : data_rdata_i;

  // rotate right by the offset, {current, first} for split accesses
  assign rdata_dbl = {data_rdata_i, rdata_lo} >> {offs_q, 3'b000};
  assign rdata_al  = rdata_dbl[lsu_pkg::bus_w_c-1:0];

  //////////////////////////////////////////////////
  // sign / zero extension
  //////////////////////////////////////////////////

  always_comb begin
    unique case (data_type_q)
      lsu_pkg::DT_BYTE: begin
        rdata_o = {{(lsu_pkg::bus_w_c-8){sign_ext_q & rdata_al[7]}}, rdata_al[7:0]};
      end
      lsu_pkg::DT_HALF: begin
        rdata_o = {{(lsu_pkg::bus_w_c-16){sign_ext_q & rdata_al[15]}}, rdata_al[15:0]};
      end
      lsu_pkg::DT_WORD: begin
        rdata_o = {{(lsu_pkg::bus_w_c-32){sign_ext_q & rdata_al[31]}}, rdata_al[31:0]};
      end
      default: begin
        // double word, aligned on the bus, no change
        rdata_o = data_rdata_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////
  // data bus geometry
  //////////////////////////////////////////////////

  // byte lanes on the data bus
  localparam int unsigned bus_bytes_c = 8;

  // data bus width in bits
  localparam int unsigned bus_w_c = 64;

  // byte offset inside one bus word
  localparam int unsigned offs_w_c = 3;

  //////////////////////////////////////////////////
  // access size
  //////////////////////////////////////////////////

  // encoding as used by the execute stage
  typedef enum logic [1:0] {
    DT_WORD   = 2'd0,
    DT_HALF   = 2'd1,
    DT_BYTE   = 2'd2,
    DT_DOUBLE = 2'd3
  } data_type_e;

endpackage

`default_nettype wire

// File: design/lsu_store_align.sv
`default_nettype none

module lsu_store_align (
  input  wire logic [lsu_pkg::offs_w_c-1:0]  addr_offs_i,
  input  wire lsu_pkg::data_type_e           data_type_i,
  input  wire logic                          second_part_i,
  input  wire logic [lsu_pkg::bus_w_c-1:0]   wdata_i,
  output logic      [lsu_pkg::bus_bytes_c-1:0] data_be_o,
  output logic      [lsu_pkg::bus_w_c-1:0]   data_wdata_o
);

  // enable pattern of the access before shifting, two bus words wide
  logic [2*lsu_pkg::bus_bytes_c-1:0] be_base;
  // pattern moved to the addressed lane, upper half spills into the next word
  logic [2*lsu_pkg::bus_bytes_c-1:0] be_shift;
  // store data repeated twice so a shift gives a rotation
  logic [2*lsu_pkg::bus_w_c-1:0]     wdata_dbl;
  logic [lsu_pkg::bus_w_c-1:0]       wdata_rot;

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    unique case (data_type_i)
      lsu_pkg::DT_WORD:
        be_base = {{(2*lsu_pkg::bus_bytes_c-4){1'b0}}, 4'b1111};
      lsu_pkg::DT_HALF:
        be_base = {{(2*lsu_pkg::bus_bytes_c-2){1'b0}}, 2'b11};
      lsu_pkg::DT_BYTE:
        be_base = {{(2*lsu_pkg::bus_bytes_c-1){1'b0}}, 1'b1};
      default:
        // double word covers the whole bus
        be_base = {{lsu_pkg::bus_bytes_c{1'b0}}, {lsu_pkg::bus_bytes_c{1'b1}}};
    endcase
  end

  // word at offset 5 gives 1110_0000 on the first part and 0000_0001 on the second
  assign be_shift = be_base << addr_offs_i;

  always_comb begin
    if (data_type_i == lsu_pkg::DT_DOUBLE) begin
      // double words are aligned, never split
      data_be_o = {lsu_pkg::bus_bytes_c{1'b1}};
    end else if (second_part_i) begin
      // lanes that spilled past the 8-byte boundary
      data_be_o = be_shift[2*lsu_pkg::bus_bytes_c-1:lsu_pkg::bus_bytes_c];
    end else begin
      data_be_o = be_shift[lsu_pkg::bus_bytes_c-1:0];
    end
  end

  //////////////////////////////////////////////////
  // store data rotation
  //////////////////////////////////////////////////

  // rotate left by the byte offset
  // low byte of the register ends up in the addressed lane
  // the same rotation serves both parts of a split store
  assign wdata_dbl = {wdata_i, wdata_i} << {addr_offs_i, 3'b000};
  assign wdata_rot = wdata_dbl[2*lsu_pkg::bus_w_c-1:lsu_pkg::bus_w_c];

  // double words go out as they are
  assign data_wdata_o = (data_type_i == lsu_pkg::DT_DOUBLE) ? wdata_i : wdata_rot;

endmodule

`default_nettype wire

// File: design/lsu_top.sv
`default_nettype none

module lsu_top #(
  parameter int unsigned ADDR_W = 32
) (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  // memory bus
  input  wire logic                            data_gnt_i,
  input  wire logic                            data_rvalid_i,
  input  wire logic                            data_err_i,
  input  wire logic [lsu_pkg::bus_w_c-1:0]     data_rdata_i,
  output logic                                 data_req_o,
  output logic      [ADDR_W-1:0]               data_addr_o,
  output logic                                 data_we_o,
  output logic      [lsu_pkg::bus_bytes_c-1:0] data_be_o,
  output logic      [lsu_pkg::bus_w_c-1:0]     data_wdata_o,
  // execute stage
  input  wire logic                            data_req_ex_i,
  input  wire logic                            data_we_ex_i,
  input  wire lsu_pkg::data_type_e             data_type_ex_i,
  input  wire logic [lsu_pkg::bus_w_c-1:0]     data_wdata_ex_i,
  input  wire logic                            data_sign_ext_ex_i,
  input  wire logic [ADDR_W-1:0]               adder_result_ex_i,
  output logic      [lsu_pkg::bus_w_c-1:0]     data_rdata_ex_o,
  output logic                                 addr_incr_req_o,
  output logic      [ADDR_W-1:0]               addr_last_o,
  output logic                                 data_valid_o,
  output logic                                 load_err_o,
  output logic                                 store_err_o,
  output logic                                 busy_o
);

  // byte position inside the bus word, same for both parts of a split access
  logic [lsu_pkg::offs_w_c-1:0] addr_offs;
  // high while the second half of a split access is on the bus
  logic                         second_part;

  assign addr_offs = adder_result_ex_i[lsu_pkg::offs_w_c-1:0];

  // bus sees only 8-byte aligned addresses
  assign data_addr_o = {adder_result_ex_i[ADDR_W-1:lsu_pkg::offs_w_c],
                        {lsu_pkg::offs_w_c{1'b0}}};
  assign data_we_o   = data_we_ex_i;

  lsu_ctrl #(
    .ADDR_W (ADDR_W)
  ) i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .data_req_ex_i   (data_req_ex_i),
    .data_type_i     (data_type_ex_i),
    .addr_i          (adder_result_ex_i),
    .we_i            (data_we_ex_i),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .data_req_o      (data_req_o),
    .addr_incr_req_o (addr_incr_req_o),
    .data_valid_o    (data_valid_o),
    .second_part_o   (second_part),
    .addr_last_o     (addr_last_o),
    .load_err_o      (load_err_o),
    .store_err_o     (store_err_o),
    .busy_o          (busy_o)
  );

  lsu_store_align i_store_align (
    .addr_offs_i   (addr_offs),
    .data_type_i   (data_type_ex_i),
    .second_part_i (second_part),
    .wdata_i       (data_wdata_ex_i),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  lsu_load_align i_load_align (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .second_part_i (second_part),
    .addr_offs_i   (addr_offs),
    .data_type_i   (data_type_ex_i),
    .sign_ext_i    (data_sign_ext_ex_i),
    .we_i          (data_we_ex_i),
    .data_rdata_i  (data_rdata_i),
    .rdata_o       (data_rdata_ex_o)
  );

endmodule

`default_nettype wire

// File: lsu.f
design/lsu_pkg.sv
design/lsu_store_align.sv
design/lsu_load_align.sv
design/lsu_ctrl.sv
design/lsu_top.sv
sim/tb_lsu.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_lsu -f lsu.f -o tb_lsu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_lsu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "Test OK"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sim/tb_lsu.sv
`default_nettype none

module tb_lsu;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period_c = 10;
  // accesses issued by all tests together
  localparam int n_access_c = 68;
  // 20 cycles per access plus a margin for reset and idle gaps
  localparam int watchdog_ns_c = (n_access_c * 20 + 100) * 2 * half_period_c;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                data_gnt;
  logic                data_rvalid;
  logic                data_err;
  logic [63:0]         data_rdata;
  logic                data_req;
  logic [31:0]         data_addr;
  logic                data_we;
  logic [7:0]          data_be;
  logic [63:0]         data_wdata;
  logic                data_req_ex;
  logic                data_we_ex;
  lsu_pkg::data_type_e data_type_ex;
  logic [63:0]         data_wdata_ex;
  logic                data_sign_ext_ex;
  logic [31:0]         adder_result_ex;
  logic [63:0]         data_rdata_ex;
  logic                addr_incr_req;
  logic [31:0]         addr_last;
  logic                data_valid;
  logic                load_err;
  logic                store_err;
  logic                busy;

  // byte-wide memory behind the bus
  logic [7:0]          mem [256];

  lsu_top #(
    .ADDR_W (32)
  ) i_dut (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .data_gnt_i         (data_gnt),
    .data_rvalid_i      (data_rvalid),
    .data_err_i         (data_err),
    .data_rdata_i       (data_rdata),
    .data_req_o         (data_req),
    .data_addr_o        (data_addr),
    .data_we_o          (data_we),
    .data_be_o          (data_be),
    .data_wdata_o       (data_wdata),
    .data_req_ex_i      (data_req_ex),
    .data_we_ex_i       (data_we_ex),
    .data_type_ex_i     (data_type_ex),
    .data_wdata_ex_i    (data_wdata_ex),
    .data_sign_ext_ex_i (data_sign_ext_ex),
    .adder_result_ex_i  (adder_result_ex),
    .data_rdata_ex_o    (data_rdata_ex),
    .addr_incr_req_o    (addr_incr_req),
    .addr_last_o        (addr_last),
    .data_valid_o       (data_valid),
    .load_err_o         (load_err),
    .store_err_o        (store_err),
    .busy_o             (busy)
  );

  always #half_period_c clk = ~clk;

  //////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////

  function automatic int size_bytes(lsu_pkg::data_type_e dt);
    case (dt)
      lsu_pkg::DT_BYTE: return 1;
      lsu_pkg::DT_HALF: return 2;
      lsu_pkg::DT_WORD: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic lsu_pkg::data_type_e pick_type(int t);
    case (t)
      0: return lsu_pkg::DT_BYTE;
      1: return lsu_pkg::DT_HALF;
      2: return lsu_pkg::DT_WORD;
      default: return lsu_pkg::DT_DOUBLE;
    endcase
  endfunction

  // access runs past the end of its 8-byte word
  function automatic bit is_split(lsu_pkg::data_type_e dt, logic [2:0] offs);
    return (int'(offs) + size_bytes(dt)) > 8;
  endfunction

  // lanes touched by one part of the access
  function automatic logic [7:0] exp_be(lsu_pkg::data_type_e dt, logic [2:0] offs, int part);
    logic [7:0] be;
    int         lane;
    be = '0;
    for (int k = 0; k < size_bytes(dt); k++) begin
      lane = int'(offs) + k - 8 * part;
      if (lane >= 0 && lane < 8) begin
        be[3'(lane)] = 1'b1;
      end
    end
    return be;
  endfunction

  // lane j carries register byte (j - offs) mod 8
  function automatic logic [63:0] exp_wdata(lsu_pkg::data_type_e dt, logic [2:0] offs,
                                            logic [63:0] wdata);
    logic [63:0] d;
    logic [2:0]  src;
    if (dt == lsu_pkg::DT_DOUBLE) begin
      return wdata;
    end
    for (int j = 0; j < 8; j++) begin
      src = 3'(j) - offs;
      d[8*j +: 8] = wdata[8*src +: 8];
    end
    return d;
  endfunction

  function automatic logic [63:0] extend(lsu_pkg::data_type_e dt, logic sext, logic [63:0] v);
    int          n;
    logic [63:0] r;
    n = 8 * size_bytes(dt);
    r = v;
    for (int b = n; b < 64; b++) begin
      r[6'(b)] = sext & v[6'(n - 1)];
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_val(name, 64'(got), 64'(exp));
  endtask

  //////////////////////////////////////////////////
  // one access, memory model serves the bus
  //////////////////////////////////////////////////

  task automatic run_access(input logic [31:0] addr, input lsu_pkg::data_type_e dt,
                            input logic we, input logic sext, input logic [63:0] wdata,
                            input int err_part, output logic [63:0] rdata, output int n_req);
    logic [63:0] exp_load;
    logic [63:0] rv_data;
    logic [31:0] bus_addr;
    logic [7:0]  idx;
    int          parts, part, wait_cnt, gnt_delay, rv_part;
    bit          req_active, rv_pending, rv_err, incr_exp, fin, done, ex_req;
    // expected load result straight from memory
    exp_load = '0;
    for (int k = size_bytes(dt) - 1; k >= 0; k--) begin
      exp_load = {exp_load[55:0], mem[8'(addr + 32'(k))]};
    end
    exp_load   = extend(dt, sext, exp_load);
    parts      = is_split(dt, addr[2:0]) ? 2 : 1;
    rdata      = '0;
    rv_data    = '0;
    n_req      = 0;
    part       = 0;
    wait_cnt   = 0;
    gnt_delay  = $urandom_range(3, 0);
    rv_part    = 0;
    req_active = 1'b1;
    rv_pending = 1'b0;
    rv_err     = 1'b0;
    incr_exp   = 1'b0;
    done       = 1'b0;
    ex_req     = 1'b1;
    @(negedge clk);
    data_we_ex       = we;
    data_type_ex     = dt;
    data_wdata_ex    = wdata;
    data_sign_ext_ex = sext;
    while (!done) begin
      // execute stage presents address + 8 on request
      data_req_ex     = ex_req;
      adder_result_ex = addr + (addr_incr_req ? 32'd8 : 32'd0);
      // bus side
      data_rvalid = rv_pending;
      data_err    = rv_pending && rv_err;
      data_rdata  = rv_pending ? rv_data : 64'h0;
      data_gnt    = req_active && (wait_cnt == gnt_delay);
      #1;
      fin = rv_pending && (rv_part == parts - 1 || rv_err);
      check_bit("busy_o", busy, 1'b1);
      check_bit("addr_incr_req_o", addr_incr_req, incr_exp);
      check_bit("data_req_o", data_req, req_active);
      check_bit("data_valid_o", data_valid, fin);
      check_bit("load_err_o", load_err, rv_pending && rv_err && !we);
      check_bit("store_err_o", store_err, rv_pending && rv_err && we);
      if (fin && !we && !rv_err) begin
        check_val("data_rdata_ex_o", data_rdata_ex, exp_load);
        rdata = data_rdata_ex;
      end
      // payload must hold its value until the grant
      if (req_active) begin
        bus_addr = (addr + 32'(8 * part)) & ~32'h7;
        check_val("data_addr_o", 64'(data_addr), 64'(bus_addr));
        check_bit("data_we_o", data_we, we);
        if (we) begin
          check_val("data_be_o", 64'(data_be), 64'(exp_be(dt, addr[2:0], part)));
          check_val("data_wdata_o", data_wdata, exp_wdata(dt, addr[2:0], wdata));
        end
      end
      done       = fin;
      rv_pending = 1'b0;
      // requests that the DUT itself puts on the bus
      if (data_req && data_gnt) begin
        n_req++;
      end
      if (data_gnt) begin
        rv_pending = 1'b1;
        rv_part    = part;
        rv_err     = (err_part == part + 1);
        for (int j = 0; j < 8; j++) begin
          idx = 8'(bus_addr + 32'(j));
          rv_data[8*j +: 8] = mem[idx];
          if (we && !rv_err && data_be[3'(j)]) begin
            mem[idx] = data_wdata[8*j +: 8];
          end
        end
        incr_exp   = (parts == 2) && (part == 0);
        ex_req     = 1'b0;
        req_active = 1'b0;
        // second request goes out with the first rvalid
        if (parts == 2 && part == 0 && !rv_err) begin
          req_active = 1'b1;
          part       = 1;
          wait_cnt   = 0;
          gnt_delay  = $urandom_range(3, 0);
        end
      end else if (req_active) begin
        wait_cnt++;
      end
      @(negedge clk);
    end
    data_req_ex = 1'b0;
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_err    = 1'b0;
    data_rdata  = '0;
    #1;
    check_bit("data_req_o", data_req, 1'b0);
    check_bit("busy_o", busy, 1'b0);
    check_bit("data_valid_o", data_valid, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_outputs();
    check_bit("data_req_o", data_req, 1'b0);
    check_bit("data_valid_o", data_valid, 1'b0);
    check_bit("addr_incr_req_o", addr_incr_req, 1'b0);
    check_bit("busy_o", busy, 1'b0);
    check_bit("load_err_o", load_err, 1'b0);
    check_bit("store_err_o", store_err, 1'b0);
    check_val("addr_last_o", 64'(addr_last), 64'h0);
  endtask

  task automatic test_aligned_round_trip();
    lsu_pkg::data_type_e dt;
    logic [31:0]         addr;
    logic [63:0]         wdata;
    logic [63:0]         rdata;
    int                  n_req;
    for (int t = 0; t < 4; t++) begin
      dt = pick_type(t);
      for (int s = 0; s < 2; s++) begin
        addr  = 32'h20 + 32'(16 * t) + 32'(s * size_bytes(dt));
        wdata = {$urandom, $urandom};
        // top bit set so extension is visible
        wdata[6'(8 * size_bytes(dt) - 1)] = 1'b1;
        run_access(addr, dt, 1'b1, s == 1, wdata, 0, rdata, n_req);
        check_val("n_req", 64'(n_req), 64'd1);
        run_access(addr, dt, 1'b0, s == 1, 64'h0, 0, rdata, n_req);
        check_val("data_rdata_ex_o", rdata, extend(dt, s == 1, wdata));
      end
    end
  endtask

  task automatic test_store_offsets();
    lsu_pkg::data_type_e dt;
    logic [31:0]         addr;
    logic [63:0]         wdata;
    logic [63:0]         rdata;
    logic [7:0]          below;
    logic [7:0]          above;
    int                  n_req;
    for (int t = 0; t < 3; t++) begin
      dt = pick_type(t);
      for (int o = 0; o < 8; o++) begin
        addr  = 32'h80 + 32'(16 * t) + 32'(o);
        wdata = {$urandom, $urandom};
        below = mem[8'(addr - 32'd1)];
        above = mem[8'(addr + 32'(size_bytes(dt)))];
        run_access(addr, dt, 1'b1, 1'b0, wdata, 0, rdata, n_req);
        check_val("n_req", 64'(n_req), is_split(dt, addr[2:0]) ? 64'd2 : 64'd1);
        check_val("addr_last_o", 64'(addr_last),
                  64'(addr + (is_split(dt, addr[2:0]) ? 32'd8 : 32'd0)));
        for (int k = 0; k < size_bytes(dt); k++) begin
          check_val("mem", 64'(mem[8'(addr + 32'(k))]), 64'(wdata[8*k +: 8]));
        end
        // neighbours untouched
        check_val("mem", 64'(mem[8'(addr - 32'd1)]), 64'(below));
        check_val("mem", 64'(mem[8'(addr + 32'(size_bytes(dt)))]), 64'(above));
      end
    end
  endtask

  task automatic test_split_loads();
    lsu_pkg::data_type_e dt;
    logic [31:0]         addr;
    logic [63:0]         rdata;
    int                  n_req;
    for (int t = 0; t < 3; t++) begin
      dt = pick_type(t);
      for (int o = 0; o < 8; o++) begin
        addr = 32'h80 + 32'(16 * t) + 32'(o);
        // value itself checked against memory inside the access
        run_access(addr, dt, 1'b0, o[0], 64'h0, 0, rdata, n_req);
        check_val("n_req", 64'(n_req), is_split(dt, addr[2:0]) ? 64'd2 : 64'd1);
      end
    end
  endtask

  task automatic test_first_part_error();
    logic [63:0] rdata;
    int          n_req;
    run_access(32'h95, lsu_pkg::DT_WORD, 1'b0, 1'b1, 64'h0, 1, rdata, n_req);
    check_val("n_req", 64'(n_req), 64'd1);
    check_val("addr_last_o", 64'(addr_last), 64'h95);
    run_access(32'hc7, lsu_pkg::DT_HALF, 1'b0, 1'b0, 64'h0, 1, rdata, n_req);
    check_val("n_req", 64'(n_req), 64'd1);
    check_val("addr_last_o", 64'(addr_last), 64'hc7);
  endtask

  task automatic test_store_error();
    logic [63:0] rdata;
    int          n_req;
    run_access(32'ha0, lsu_pkg::DT_WORD, 1'b1, 1'b0, {$urandom, $urandom}, 1, rdata, n_req);
    check_val("n_req", 64'(n_req), 64'd1);
    // error on the second half of a split store
    run_access(32'ha6, lsu_pkg::DT_WORD, 1'b1, 1'b0, {$urandom, $urandom}, 2, rdata, n_req);
    check_val("n_req", 64'(n_req), 64'd2);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h923c6441));
    rst_n            = 1'b0;
    data_gnt         = 1'b0;
    data_rvalid      = 1'b0;
    data_err         = 1'b0;
    data_rdata       = '0;
    data_req_ex      = 1'b0;
    data_we_ex       = 1'b0;
    data_type_ex     = lsu_pkg::DT_WORD;
    data_wdata_ex    = '0;
    data_sign_ext_ex = 1'b0;
    adder_result_ex  = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'h3c;
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    #1;
    test_reset_outputs();
    test_aligned_round_trip();
    test_store_offsets();
    test_split_loads();
    test_first_part_error();
    test_store_error();
    $display("Test OK");
    $finish;
  end

  initial begin
    #(watchdog_ns_c);
    $display("watchdog expired, an access did not finish in time");
    $display("Test FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire
